//--- files.f
hw/vga_reg_pkg.sv
hw/vga_mem_pkg.sv
hw/vga_regs.sv
hw/vga_timing.sv
hw/vga_fetch.sv
hw/pixel_fifo.sv
hw/vga_scanout.sv
hw/vga_top.sv
dv/vga_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = vga_tb
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/vga_tb.sv
// VGA controller testbench
// Drives Wishbone register traffic, models the memory bus, and checks
// sync, blank, fetch requests and pixels against a raster model.
`timescale 1ns/100ps
module vga_tb;
  import vga_reg_pkg::*;
  import vga_mem_pkg::*;

  localparam int mem_words = 4096;
  localparam int cycle_limit = 2 * (800 * 525 + 120 * 120);

  logic        vga_clk = 1'b0;
  logic        mem_reset = 1'b1;
  wb_req_t     wb_req = '0;
  wb_rsp_t     wb_rsp;
  mem_req_t    mem_req;
  logic        mem_ready = 1'b0;
  mem_rsp_t    mem_rsp = '0;
  logic        vga_hsync, vga_hblank, vga_vsync, vga_vblank;
  logic [23:0] vga_rgb;

  mem_word_t   mem_arr [mem_words];
  int unsigned addr_q [$];   // expected bursts
  int unsigned len_q [$];
  mem_word_t   rsp_q [$];
  logic        last_q [$];
  int          delay = 0;

  // raster model state
  vga_mode_t   mm;
  vga_mode_t   new_mode;
  int          mh, mv, frames, cycles;
  int          line_idx, line_addr_m, line_words;
  logic        e_hs, e_hb, e_vs, e_vb, e_ls, load_next;
  logic [23:0] e_rgb;

  vga_top u_vga_top (.*);

  always #20 vga_clk = ~vga_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
      fail_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  function automatic logic win(input int c, input int s, input int w);
    return c > s && c <= s + w;
  endfunction

  // stb drops on the edge where ack is seen
  task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdat,
                            output logic got_ack, output logic got_err);
    int n = 0;
    @(posedge vga_clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    do begin
      @(posedge vga_clk);
      n++;
      if (n > 8) fail_run("no Wishbone response within 8 cycles");
    end while (!(wb_rsp.ack || wb_rsp.err));
    rdat    = wb_rsp.dat;
    got_ack = wb_rsp.ack;
    got_err = wb_rsp.err;
    wb_req <= '0;
  endtask

  // ------------------------------------------------------------
  // memory model
  // ------------------------------------------------------------
  always @(posedge vga_clk) begin
    if (mem_reset) begin
      mem_ready <= 1'b0;
      mem_rsp   <= '0;
      rsp_q.delete();
      last_q.delete();
    end else begin
      if (rsp_q.size() > 0) begin
        mem_rsp <= '{valid: 1'b1, data: rsp_q.pop_front(), last: last_q.pop_front()};
      end else begin
        mem_rsp <= '0;
      end
      if (mem_req.valid && mem_ready) begin
        if (addr_q.size() == 0) fail_run("memory request with no line pending");
        check("mem_req.addr", addr_q.pop_front(), mem_req.addr);
        check("mem_req.len", len_q.pop_front(), 32'(mem_req.len));
        if ((mem_req.addr % page_bytes) / word_bytes + mem_req.len >= page_bytes / word_bytes)
          fail_run("burst crosses a 4 KB page");
        for (int i = 0; i <= int'(mem_req.len); i++) begin
          rsp_q.push_back(mem_arr[(mem_req.addr / word_bytes + i) % mem_words]);
          last_q.push_back(i == int'(mem_req.len));
        end
        mem_ready <= 1'b0;
        delay = $urandom % 4;
      end else if (mem_req.valid) begin
        if (delay == 0) mem_ready <= 1'b1;
        else delay--;
      end
    end
  end

  // ------------------------------------------------------------
  // raster and pixel model
  // ------------------------------------------------------------
  // outputs seen here were set on the previous edge
  always @(posedge vga_clk) begin
    int   p, room, vn;
    cycles++;
    if (cycles > cycle_limit) fail_run("timeout, raster did not finish");
    if (mem_reset) begin
      mm = mode_reset;
      {mh, mv, frames, line_words} = '0;
      {e_hs, e_hb, e_vs, e_vb, e_ls, load_next} = '0;
      e_rgb = '0;
      addr_q.delete();
      len_q.delete();
    end else begin
      check("vga_hsync", e_hs, vga_hsync);
      check("vga_hblank", e_hb, vga_hblank);
      check("vga_vsync", e_vs, vga_vsync);
      check("vga_vblank", e_vb, vga_vblank);
      if (e_hb || !e_vb) check("vga_rgb", e_rgb, vga_rgb);

      if (e_ls) begin   // fetcher acts on line_start now
        line_addr_m = mm.disp_addr + line_idx * mm.pitch;
        line_words  = mm.pitch / word_bytes;
        room        = (page_bytes - line_addr_m % page_bytes) / word_bytes;
        if (line_words > room) begin
          addr_q.push_back(line_addr_m);
          len_q.push_back(room - 1);
          addr_q.push_back(line_addr_m + room * word_bytes);
          len_q.push_back(line_words - room - 1);
        end else if (line_words > 0) begin
          addr_q.push_back(line_addr_m);
          len_q.push_back(line_words - 1);
        end
      end

      e_hb = !win(mh, mm.h_start, mm.h_width);
      e_hs = mm.hpol ^ (mh > int'(mm.h_total) - int'(mm.h_sync));
      e_vb = !win(mv, mm.v_start, mm.v_width);
      e_vs = mm.vpol ^ (mv > int'(mm.v_total) - int'(mm.v_sync));
      e_rgb = '0;
      if (!e_hb) begin
        p = mh - mm.h_start - 1;
        if (p / 128 < line_words &&
            mem_arr[(line_addr_m / word_bytes + p / 128) % mem_words][p % 128])
          e_rgb = '1;
      end

      if (load_next) begin
        mh = 0;
        mv = 0;
        e_ls = 1'b0;
        frames = 0;
      end else begin
        vn   = (mv == mm.v_total) ? 0 : mv + 1;
        e_ls = (mh == mm.h_total) && win(vn, mm.v_start, mm.v_width);
        if (e_ls) line_idx = vn - mm.v_start - 1;
        if (mh == mm.h_total) begin
          mh = 0;
          mv = vn;
          if (vn == 0) frames++;
        end else begin
          mh++;
        end
      end
      // slave takes the load_mode write on this edge
      load_next = wb_req.cyc && wb_req.stb && wb_req.we && wb_req.adr == load_mode &&
                  wb_req.sel[0] && !wb_rsp.ack && !wb_rsp.err;
      if (load_next) mm = new_mode;
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    logic [11:0] offs [7];
    logic [31:0] masks [7];
    logic [31:0] shadow [7];
    logic [11:0] bad [3];
    logic [31:0] rdat, dat, lane;
    logic [3:0]  sel;
    logic        ack, err;
    int          k;
    void'($urandom(32'h36fd));
    offs   = '{h_disp_start_width, h_sync_total, v_disp_start_width, v_sync_total,
               polarity_reg, display_addr, display_pitch};
    masks  = '{32'h0fff0fff, 32'h0fff0fff, 32'h0fff0fff, 32'h0fff0fff,
               32'h3, 32'hffffffff, 32'h1fff};
    shadow = '{32'h0280002f, 32'h031f0060, 32'h01e0001f, 32'h020c0002, 0, 0, 32'h50};
    bad    = '{12'h020, 12'h200, 12'h10c};
    cycles = 0;
    for (int i = 0; i < mem_words; i++)
      mem_arr[i] = {$urandom, $urandom, $urandom, $urandom};
    repeat (2) @(posedge vga_clk);
    mem_reset <= 1'b0;

    for (int n = 0; n < 40; n++) begin   // random byte-lane writes
      k   = $urandom % 7;
      dat = $urandom;
      sel = $urandom % 16;
      for (int b = 0; b < 4; b++) lane[8*b +: 8] = {8{sel[b]}};
      bus_access(1'b1, offs[k], dat, sel, rdat, ack, err);
      check("wb_rsp.ack", 1, ack);
      shadow[k] = ((shadow[k] & ~lane) | (dat & lane)) & masks[k];
      bus_access(1'b0, offs[k], '0, 4'hf, rdat, ack, err);
      check("wb_rsp.dat", shadow[k], rdat);
    end
    foreach (bad[i]) begin
      bus_access(i % 2, bad[i], $urandom, 4'hf, rdat, ack, err);
      check("wb_rsp.err", 1, err);
      check("wb_rsp.ack", 0, ack);
    end

    while (mv < 35) @(posedge vga_clk);   // a few fetched reset-mode lines

    new_mode = '{h_start: 16 + $urandom % 8, h_width: 20 + $urandom % 16,
                 h_sync: 4 + $urandom % 9, h_total: 60 + $urandom % 60,
                 v_start: 3 + $urandom % 4, v_width: 10 + $urandom % 11,
                 v_sync: 1 + $urandom % 3, v_total: 40 + $urandom % 60,
                 hpol: $urandom % 2, vpol: $urandom % 2,
                 disp_addr: 32'hff0, pitch: 13'd32};   // line 0 straddles a page
    bus_access(1'b1, h_disp_start_width, {4'h0, new_mode.h_width, 4'h0, new_mode.h_start},
               4'hf, rdat, ack, err);
    bus_access(1'b1, h_sync_total, {4'h0, new_mode.h_total, 4'h0, new_mode.h_sync},
               4'hf, rdat, ack, err);
    bus_access(1'b1, v_disp_start_width, {4'h0, new_mode.v_width, 4'h0, new_mode.v_start},
               4'hf, rdat, ack, err);
    bus_access(1'b1, v_sync_total, {4'h0, new_mode.v_total, 4'h0, new_mode.v_sync},
               4'hf, rdat, ack, err);
    bus_access(1'b1, polarity_reg, {30'h0, new_mode.hpol, new_mode.vpol}, 4'hf, rdat, ack, err);
    bus_access(1'b1, display_addr, new_mode.disp_addr, 4'hf, rdat, ack, err);
    bus_access(1'b1, display_pitch, 32'(new_mode.pitch), 4'hf, rdat, ack, err);
    bus_access(1'b1, load_mode, 32'h1, 4'h1, rdat, ack, err);

    while (frames < 2) @(posedge vga_clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- hw/vga_top.sv
// VGA display controller top
// Register file, raster timing, line fetcher, pixel FIFO and
// scan-out stage, all on vga_clk.
`timescale 1ns/100ps
module vga_top (
  input  logic                  vga_clk,
  input  logic                  mem_reset,
  input  vga_reg_pkg::wb_req_t  wb_req,
  output vga_reg_pkg::wb_rsp_t  wb_rsp,
  output vga_mem_pkg::mem_req_t mem_req,
  input  logic                  mem_ready,
  input  vga_mem_pkg::mem_rsp_t mem_rsp,
  output logic                  vga_hsync,
  output logic                  vga_hblank,
  output logic                  vga_vsync,
  output logic                  vga_vblank,
  output logic [23:0]           vga_rgb
);
  import vga_reg_pkg::*;
  import vga_mem_pkg::*;

  vga_mode_t          mode;
  logic               load;
  logic [coord_w-1:0] horiz_count;
  logic               line_start;
  logic [coord_w-1:0] line_index;
  logic               flush;
  logic               pop;
  mem_word_t          fifo_data;
  logic               fifo_empty;

  vga_regs u_regs (
    .vga_clk, .mem_reset, .wb_req, .wb_rsp, .mode, .load
  );

  vga_timing u_timing (
    .vga_clk, .mem_reset, .mode, .load, .horiz_count, .line_start, .line_index,
    .vga_hsync, .vga_hblank, .vga_vsync, .vga_vblank
  );

  vga_fetch u_fetch (
    .vga_clk, .mem_reset, .mode, .line_start, .line_index,
    .mem_req, .mem_ready, .flush
  );

  pixel_fifo u_fifo (
    .vga_clk, .mem_reset, .flush, .wr(mem_rsp), .pop,
    .data(fifo_data), .empty(fifo_empty)
  );

  vga_scanout u_scanout (
    .vga_clk, .mem_reset, .mode, .horiz_count,
    .data(fifo_data), .empty(fifo_empty), .pop, .vga_rgb
  );

endmodule

//--- hw/vga_scanout.sv
// VGA scan-out
// Serializes FIFO words into pixels inside the active window, one
// bit per pixel shown as white or black. Pops the FIFO after the
// last bit of each word and shows black when the FIFO runs dry.
`timescale 1ns/100ps
module vga_scanout (
  input  logic                            vga_clk,
  input  logic                            mem_reset,
  input  vga_reg_pkg::vga_mode_t          mode,
  input  logic [vga_reg_pkg::coord_w-1:0] horiz_count,
  input  vga_mem_pkg::mem_word_t          data,
  input  logic                            empty,
  output logic                            pop,
  output logic [23:0]                     vga_rgb
);
  import vga_reg_pkg::*;
  import vga_mem_pkg::*;

  logic                          active;
  logic [coord_w-1:0]            pix;       // pixel number within the line
  logic [$clog2(mem_word_w)-1:0] bit_idx;   // bit within current word

  always_comb begin
    active  = in_window(horiz_count, mode.h_start, mode.h_width);
    pix     = horiz_count - mode.h_start - 1'b1;
    bit_idx = pix[$bits(bit_idx)-1:0];
  end

  // last bit of a word shown this cycle
  assign pop = active && !empty && (bit_idx == '1);

  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      vga_rgb <= '0;
    end else if (active && !empty && data[bit_idx]) begin
      vga_rgb <= '1;
    end else begin
      vga_rgb <= '0;
    end
  end

endmodule

//--- hw/pixel_fifo.sv
// Pixel FIFO
// Synchronous first-word-fall-through FIFO of memory words, deep
// enough for one scan line. Cleared by flush at each line start.
`timescale 1ns/100ps
module pixel_fifo (
  input  logic                   vga_clk,
  input  logic                   mem_reset,
  input  logic                   flush,
  input  vga_mem_pkg::mem_rsp_t  wr,
  input  logic                   pop,
  output vga_mem_pkg::mem_word_t data,
  output logic                   empty
);
  import vga_mem_pkg::*;

  mem_word_t             mem [fifo_depth];
  logic [fifo_ptr_w:0]   wr_ptr;   // extra bit tells full from empty
  logic [fifo_ptr_w:0]   rd_ptr;
  logic                  full;

  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[fifo_ptr_w] != rd_ptr[fifo_ptr_w]) &&
                 (wr_ptr[fifo_ptr_w-1:0] == rd_ptr[fifo_ptr_w-1:0]);
  assign data  = mem[rd_ptr[fifo_ptr_w-1:0]];   // head word, no read latency

  always_ff @(posedge vga_clk) begin
    if (mem_reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr.valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge vga_clk) begin
    if (wr.valid) mem[wr_ptr[fifo_ptr_w-1:0]] <= wr.data;
  end

  // no back-pressure on responses, so a line must always fit
  a_no_overflow: assert property (@(posedge vga_clk) disable iff (mem_reset)
    wr.valid |-> !full);

endmodule

//--- hw/vga_fetch.sv
// VGA line fetcher
// On each line start computes the line address and word count,
// flushes the pixel FIFO and requests the line from memory. A span
// that crosses a 4 KB page goes out as two bursts.
`timescale 1ns/100ps
module vga_fetch (
  input  logic                            vga_clk,
  input  logic                            mem_reset,
  input  vga_reg_pkg::vga_mode_t          mode,
  input  logic                            line_start,
  input  logic [vga_reg_pkg::coord_w-1:0] line_index,
  output vga_mem_pkg::mem_req_t           mem_req,
  input  logic                            mem_ready,
  output logic                            flush
);
  import vga_reg_pkg::*;
  import vga_mem_pkg::*;

  logic [31:0]            line_addr;
  logic [pitch_w-1:0]     words;      // line length in memory words
  logic [pitch_w-1:0]     room;       // words left before the page ends
  logic                   split;
  logic                   req_valid;
  logic [31:0]            req_addr;
  logic [burst_len_w-1:0] req_len;
  logic                   second_pend;
  logic [31:0]            second_addr;
  logic [burst_len_w-1:0] second_len;

  always_comb begin
    line_addr = mode.disp_addr + 32'(line_index) * 32'(mode.pitch);
    words     = mode.pitch / pitch_w'(word_bytes);
    room      = pitch_w'((page_bytes - (line_addr % page_bytes)) / word_bytes);
    split     = words > room;
  end

  assign mem_req = '{valid: req_valid, addr: req_addr, len: req_len};

  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      req_valid   <= 1'b0;
      second_pend <= 1'b0;
      flush       <= 1'b0;
    end else begin
      flush <= line_start;
      if (line_start) begin
        req_valid   <= words != '0;
        second_pend <= split;
      end else if (req_valid && mem_ready) begin
        req_valid   <= second_pend;   // second half goes out next cycle
        second_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge vga_clk) begin
    if (line_start) begin
      req_addr    <= line_addr;
      req_len     <= split ? burst_len_w'(room - 1'b1) : burst_len_w'(words - 1'b1);
      second_addr <= line_addr - (line_addr % page_bytes) + page_bytes;
      second_len  <= burst_len_w'(words - room - 1'b1);
    end else if (req_valid && mem_ready && second_pend) begin
      req_addr <= second_addr;
      req_len  <= second_len;
    end
  end

  a_req_stable: assert property (@(posedge vga_clk) disable iff (mem_reset)
    req_valid && !mem_ready |=> req_valid && $stable(req_addr) && $stable(req_len));

endmodule

//--- hw/vga_timing.sv
// VGA raster timing generator
// Horizontal and vertical counters with registered sync and blank
// outputs, one cycle behind the count they describe. Restarts the
// raster on load and pulses line_start at the head of each active line.
`timescale 1ns/100ps
module vga_timing (
  input  logic                            vga_clk,
  input  logic                            mem_reset,
  input  vga_reg_pkg::vga_mode_t          mode,
  input  logic                            load,
  output logic [vga_reg_pkg::coord_w-1:0] horiz_count,
  output logic                            line_start,
  output logic [vga_reg_pkg::coord_w-1:0] line_index,
  output logic                            vga_hsync,
  output logic                            vga_hblank,
  output logic                            vga_vsync,
  output logic                            vga_vblank
);
  import vga_reg_pkg::*;

  logic [coord_w-1:0] vert_count;
  logic [coord_w-1:0] vert_next;
  logic               h_wrap;

  // count > total - sync, written so it cannot underflow
  function automatic logic sync_on(input logic [coord_w-1:0] c,
                                   input logic [coord_w-1:0] sync,
                                   input logic [coord_w-1:0] total);
    return ({1'b0, c} + {1'b0, sync}) > {1'b0, total};
  endfunction

  assign h_wrap    = horiz_count >= mode.h_total;
  assign vert_next = (vert_count >= mode.v_total) ? '0 : vert_count + 1'b1;

  // ------------------------------------------------------------
  // raster counters
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk) begin
    if (mem_reset || load) begin   // new mode restarts the frame
      horiz_count <= '0;
      vert_count  <= '0;
      line_start  <= 1'b0;
    end else begin
      line_start <= h_wrap && in_window(vert_next, mode.v_start, mode.v_width);
      if (h_wrap) begin
        horiz_count <= '0;
        vert_count  <= vert_next;
      end else begin
        horiz_count <= horiz_count + 1'b1;
      end
    end
  end

  always_ff @(posedge vga_clk) begin
    if (h_wrap) line_index <= vert_next - mode.v_start - 1'b1;
  end

  // ------------------------------------------------------------
  // sync and blank
  // ------------------------------------------------------------
  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      vga_hsync  <= 1'b0;
      vga_hblank <= 1'b0;
      vga_vsync  <= 1'b0;
      vga_vblank <= 1'b0;
    end else begin
      vga_hblank <= !in_window(horiz_count, mode.h_start, mode.h_width);
      vga_hsync  <= mode.hpol ^ sync_on(horiz_count, mode.h_sync, mode.h_total);
      vga_vblank <= !in_window(vert_count, mode.v_start, mode.v_width);
      vga_vsync  <= mode.vpol ^ sync_on(vert_count, mode.v_sync, mode.v_total);
    end
  end

endmodule

//--- hw/vga_regs.sv
// VGA register file
// Wishbone classic slave holding a shadow copy of the display mode.
// A write to load_mode publishes the shadow as the active mode and
// pulses load for one cycle. Reads return the shadow.
`timescale 1ns/100ps
module vga_regs (
  input  logic                   vga_clk,
  input  logic                   mem_reset,
  input  vga_reg_pkg::wb_req_t   wb_req,
  output vga_reg_pkg::wb_rsp_t   wb_rsp,
  output vga_reg_pkg::vga_mode_t mode,
  output logic                   load
);
  import vga_reg_pkg::*;

  vga_mode_t   shadow;
  logic        ack;
  logic        err;
  logic [31:0] rd_dat;
  logic        req_seen;
  logic        do_load;
  logic        mapped;
  logic [31:0] cur_img;   // shadow view of the addressed register
  logic [31:0] wr_img;    // cur_img with selected lanes replaced

  assign req_seen = wb_req.cyc && wb_req.stb && !ack && !err;
  assign do_load  = req_seen && wb_req.we && (wb_req.adr == load_mode) && wb_req.sel[0];
  assign wb_rsp   = '{ack: ack, err: err, dat: rd_dat};

  always_comb begin
    mapped  = 1'b1;
    cur_img = '0;
    case (wb_req.adr)
      h_disp_start_width: cur_img = {4'h0, shadow.h_width, 4'h0, shadow.h_start};
      h_sync_total:       cur_img = {4'h0, shadow.h_total, 4'h0, shadow.h_sync};
      v_disp_start_width: cur_img = {4'h0, shadow.v_width, 4'h0, shadow.v_start};
      v_sync_total:       cur_img = {4'h0, shadow.v_total, 4'h0, shadow.v_sync};
      polarity_reg:       cur_img = {30'h0, shadow.hpol, shadow.vpol};
      display_addr:       cur_img = shadow.disp_addr;
      display_pitch:      cur_img = 32'(shadow.pitch);
      load_mode:          cur_img = '0;   // write-only strobe
      default:            mapped  = 1'b0;
    endcase
    for (int i = 0; i < 4; i++) begin
      wr_img[8*i +: 8] = wb_req.sel[i] ? wb_req.dat[8*i +: 8] : cur_img[8*i +: 8];
    end
  end

  always_ff @(posedge vga_clk) begin
    if (mem_reset) begin
      ack    <= 1'b0;
      err    <= 1'b0;
      load   <= 1'b0;
      shadow <= mode_reset;
      mode   <= mode_reset;
    end else begin
      ack  <= req_seen && mapped;
      err  <= req_seen && !mapped;
      load <= do_load;
      if (do_load) mode <= shadow;
      if (req_seen && wb_req.we) begin
        case (wb_req.adr)
          h_disp_start_width: begin
            shadow.h_start <= wr_img[11:0];
            shadow.h_width <= wr_img[27:16];
          end
          h_sync_total: begin
            shadow.h_sync  <= wr_img[11:0];
            shadow.h_total <= wr_img[27:16];
          end
          v_disp_start_width: begin
            shadow.v_start <= wr_img[11:0];
            shadow.v_width <= wr_img[27:16];
          end
          v_sync_total: begin
            shadow.v_sync  <= wr_img[11:0];
            shadow.v_total <= wr_img[27:16];
          end
          polarity_reg: begin
            shadow.hpol <= wr_img[1];
            shadow.vpol <= wr_img[0];
          end
          display_addr:  shadow.disp_addr <= wr_img;
          display_pitch: shadow.pitch     <= wr_img[pitch_w-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge vga_clk) begin
    if (req_seen) rd_dat <= cur_img;
  end

  // master releases stb once answered
  a_stb_release: assert property (@(posedge vga_clk) disable iff (mem_reset)
    wb_rsp.ack || wb_rsp.err |=> !wb_req.stb);

endmodule

//--- hw/vga_mem_pkg.sv
// VGA memory package
// Memory word, burst request and response structs, page and word
// size constants and the pixel FIFO depth.
package vga_mem_pkg;

  localparam int mem_word_w  = 128;
  localparam int word_bytes  = 16;
  localparam int page_bytes  = 4096;   // bursts never cross this
  localparam int burst_len_w = 8;

  localparam int fifo_depth  = 32;     // one full line of words
  localparam int fifo_ptr_w  = $clog2(fifo_depth);

  typedef logic [mem_word_w-1:0] mem_word_t;

  typedef struct packed {
    logic                   valid;
    logic [31:0]            addr;
    logic [burst_len_w-1:0] len;   // words minus one
  } mem_req_t;

  typedef struct packed {
    logic      valid;
    mem_word_t data;
    logic      last;   // final word of a burst
  } mem_rsp_t;

endpackage

//--- hw/vga_reg_pkg.sv
// VGA register package
// Register map, display mode layout and reset mode, plus the
// Wishbone classic request and response structs.
package vga_reg_pkg;

  localparam int coord_w    = 12;
  localparam int pitch_w    = 13;
  localparam int reg_addr_w = 12;

  // ------------------------------------------------------------
  // register byte offsets
  // ------------------------------------------------------------
  localparam logic [reg_addr_w-1:0] h_disp_start_width = 12'h000;
  localparam logic [reg_addr_w-1:0] h_sync_total       = 12'h004;
  localparam logic [reg_addr_w-1:0] v_disp_start_width = 12'h008;
  localparam logic [reg_addr_w-1:0] v_sync_total       = 12'h00c;
  localparam logic [reg_addr_w-1:0] polarity_reg       = 12'h010;
  localparam logic [reg_addr_w-1:0] display_addr       = 12'h100;
  localparam logic [reg_addr_w-1:0] display_pitch      = 12'h104;
  localparam logic [reg_addr_w-1:0] load_mode          = 12'h108;

  typedef struct packed {
    logic [coord_w-1:0] h_start;
    logic [coord_w-1:0] h_width;
    logic [coord_w-1:0] h_sync;
    logic [coord_w-1:0] h_total;
    logic [coord_w-1:0] v_start;
    logic [coord_w-1:0] v_width;
    logic [coord_w-1:0] v_sync;
    logic [coord_w-1:0] v_total;
    logic               hpol;
    logic               vpol;
    logic [31:0]        disp_addr;
    logic [pitch_w-1:0] pitch;     // bytes per line
  } vga_mode_t;

  // 640x480
  localparam vga_mode_t mode_reset = '{
    h_start: 12'd47, h_width: 12'd640, h_sync: 12'd96, h_total: 12'd799,
    v_start: 12'd31, v_width: 12'd480, v_sync: 12'd2,  v_total: 12'd524,
    hpol: 1'b0, vpol: 1'b0, disp_addr: 32'h0, pitch: 13'd80
  };

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [reg_addr_w-1:0] adr;
    logic [31:0]           dat;
    logic [3:0]            sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  // start < c <= start + width, no wrap on the sum
  function automatic logic in_window(input logic [coord_w-1:0] c,
                                     input logic [coord_w-1:0] start,
                                     input logic [coord_w-1:0] width);
    return (c > start) && ({1'b0, c} <= {1'b0, start} + {1'b0, width});
  endfunction

endpackage
